//--- hw/user_io_consts.svh
// shared command codes, widths and PS/2 timing for the user I/O block; include where needed
`ifndef USER_IO_CONSTS_SVH
`define USER_IO_CONSTS_SVH

// SPI framing
// one SPI byte
`define USER_IO_BYTE_W 8
// byte index within a frame, saturates at its top value
`define USER_IO_IDX_W 4

// command codes sent as the first byte of a frame
// buttons and switches in one byte
`define USER_IO_CMD_BUT_SW 8'h01
// keyboard scan code bytes
`define USER_IO_CMD_KBD 8'h05
// status from a single byte, upper bytes cleared
`define USER_IO_CMD_STATUS8 8'h15
// status bytes 1 to 8, least significant first
`define USER_IO_CMD_STATUS64 8'h1e
// digital joysticks, four bytes each, least significant first
`define USER_IO_CMD_JOY0 8'h60
`define USER_IO_CMD_JOY1 8'h61

// scan code prefixes
// extended key
`define USER_IO_KBD_EXT 8'he0
// key release
`define USER_IO_KBD_BREAK 8'hf0

// register widths
`define USER_IO_JOY_W 32
`define USER_IO_STATUS_W 64

// PS/2 keyboard path
// queue entries, a power of two
`define USER_IO_PS2_FIFO_DEPTH 8
// clk_sys cycles per half period of the PS/2 clock
`define USER_IO_PS2_DIV 4

`endif

//--- hw/user_io_pkg.sv
// types shared by the command decoder and the top level; import where the joystick word is used
`include "user_io_consts.svh"

package user_io_pkg;

	// joystick word, seen flat on the output port
	// or as byte lanes while the decoder fills it
	typedef union packed {
		logic [`USER_IO_JOY_W-1:0] word;
		// lane 0 is the first byte after the command
		logic [`USER_IO_JOY_W/`USER_IO_BYTE_W-1:0][`USER_IO_BYTE_W-1:0] lane;
	} joy_word_u;

endpackage

//--- hw/spi_byte_if.sv
// byte stream from the SPI receiver to the command decoder; one instance lives in the top level
`timescale 1ns/1ps
`include "user_io_consts.svh"

interface spi_byte_if;

	// one-cycle pulse per byte after the command byte
	logic valid;
	// received byte, stable from valid until the next byte
	logic [`USER_IO_BYTE_W-1:0] data;
	// position of data within the frame, 1 is the first byte after cmd
	logic [`USER_IO_IDX_W-1:0] idx;
	// first byte of the current frame
	logic [`USER_IO_BYTE_W-1:0] cmd;

	// receiver side drives everything
	modport rx (output valid, output data, output idx, output cmd);

	// decoder only listens
	modport dec (input valid, input data, input idx, input cmd);

endinterface

//--- hw/spi_byte_rx.sv
// SPI slave oversampled by clk_sys; assembles MOSI bytes and marks their place in the frame
`timescale 1ns/1ps
`include "user_io_consts.svh"

module spi_byte_rx (
	input  logic      clk_sys,
	input  logic      SPI_SS_IO,
	input  logic      SPI_CLK,
	input  logic      SPI_MOSI,
	spi_byte_if.rx    bus
);

	// two sync stages plus one delayed copy for the edge detector
	logic [2:0] sck_sync;
	// MOSI runs through the same two stages so it lines up with the edge
	logic [1:0] mosi_sync;
	// first seven bits of the byte, MSB first
	logic [`USER_IO_BYTE_W-2:0] shift;
	logic [2:0] bit_cnt;
	// bytes seen so far in this frame, saturating
	logic [`USER_IO_IDX_W-1:0] byte_cnt;

	logic sck_rise;
	logic [`USER_IO_BYTE_W-1:0] rx_byte;

	// rising SPI_CLK seen after the second sync stage
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	// complete byte once the eighth bit is sampled
	assign rx_byte = {shift, mosi_sync[1]};

	// SS high ends the frame and holds everything cleared
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sck_sync <= '0;
			mosi_sync <= '0;
			shift <= '0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			bus.valid <= 1'b0;
			bus.data <= '0;
			bus.idx <= '0;
			bus.cmd <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], SPI_CLK};
			mosi_sync <= {mosi_sync[0], SPI_MOSI};
			bus.valid <= 1'b0;

			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					// byte 0 is the command, only latched here
					if (byte_cnt == '0) begin
						bus.cmd <= rx_byte;
					end else begin
						bus.valid <= 1'b1;
						bus.data <= rx_byte;
						bus.idx <= byte_cnt;
					end
					// stop counting at the top, long frames keep the last index
					if (byte_cnt != '1)
						byte_cnt <= byte_cnt + 1'b1;
				end else begin
					shift <= {shift[`USER_IO_BYTE_W-3:0], mosi_sync[1]};
				end
			end
		end
	end

endmodule

//--- hw/io_cmd_decoder.sv
// decodes received SPI bytes into the core registers and feeds keyboard bytes to the PS/2 queue
`timescale 1ns/1ps
`include "user_io_consts.svh"

module io_cmd_decoder (
	input  logic                          clk_sys,
	input  logic                          SPI_SS_IO,
	spi_byte_if.dec                       bus,
	output logic [1:0]                    buttons,
	output logic [1:0]                    switches,
	output user_io_pkg::joy_word_u        joystick_0,
	output user_io_pkg::joy_word_u        joystick_1,
	output logic [`USER_IO_STATUS_W-1:0]  status,
	output logic                          key_pressed,
	output logic                          key_extended,
	output logic [`USER_IO_BYTE_W-1:0]    key_code,
	output logic                          key_strobe,
	output logic                          kbd_push,
	output logic [`USER_IO_BYTE_W-1:0]    kbd_push_data
);

	import user_io_pkg::*;

	// joystick bytes collect here until the fourth one arrives
	joy_word_u joy_stage;
	// buttons in 1..0, switches in 3..2
	logic [3:0] but_sw;
	// prefixes seen so far in the current keyboard frame
	logic key_ext_r;
	logic key_rel_r;

	logic is_joy;
	logic kbd_valid;
	logic kbd_first;
	logic kbd_prefix;
	logic [1:0] joy_lane;
	logic [2:0] status_lane;

	assign buttons = but_sw[1:0];
	assign switches = but_sw[3:2];

	assign is_joy = (bus.cmd == `USER_IO_CMD_JOY0) || (bus.cmd == `USER_IO_CMD_JOY1);
	// lanes 0..3 for bytes 1..4
	assign joy_lane = bus.idx[1:0] - 2'd1;
	// lanes 0..7 for bytes 1..8
	assign status_lane = 3'(bus.idx - 1'b1);

	assign kbd_valid = bus.valid && (bus.cmd == `USER_IO_CMD_KBD);
	// byte 1 restarts the prefix tracking
	assign kbd_first = (bus.idx == `USER_IO_IDX_W'(1));
	assign kbd_prefix = (bus.data == `USER_IO_KBD_EXT) || (bus.data == `USER_IO_KBD_BREAK);

	// received values, kept across frames
	always_ff @(posedge clk_sys) begin
		if (bus.valid) begin
			case (bus.cmd)
				`USER_IO_CMD_BUT_SW: but_sw <= bus.data[3:0];
				`USER_IO_CMD_STATUS8: begin
					if (kbd_first)
						status <= {{(`USER_IO_STATUS_W - `USER_IO_BYTE_W){1'b0}}, bus.data};
				end
				`USER_IO_CMD_STATUS64: begin
					// bytes past the eighth are ignored
					if (bus.idx <= `USER_IO_IDX_W'(8))
						status[status_lane*`USER_IO_BYTE_W +: `USER_IO_BYTE_W] <= bus.data;
				end
				default: ;
			endcase

			if (is_joy && (bus.idx <= `USER_IO_IDX_W'(4))) begin
				joy_stage.lane[joy_lane] <= bus.data;
				// byte 4 completes the word, lane 3 comes straight from the bus
				if (bus.idx == `USER_IO_IDX_W'(4)) begin
					if (bus.cmd == `USER_IO_CMD_JOY0) begin
						joystick_0.lane[3] <= bus.data;
						joystick_0.lane[2:0] <= joy_stage.lane[2:0];
					end else begin
						joystick_1.lane[3] <= bus.data;
						joystick_1.lane[2:0] <= joy_stage.lane[2:0];
					end
				end
			end
		end

		// every keyboard byte also goes to the PS/2 queue
		kbd_push_data <= bus.data;

		// scan code outputs hold until the next code
		if (kbd_valid && !kbd_prefix) begin
			key_code <= bus.data;
			key_extended <= key_ext_r & ~kbd_first;
			key_pressed <= ~(key_rel_r & ~kbd_first);
		end
	end

	// prefix flags and strobes
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			key_ext_r <= 1'b0;
			key_rel_r <= 1'b0;
			key_strobe <= 1'b0;
			kbd_push <= 1'b0;
		end else begin
			key_strobe <= kbd_valid && !kbd_prefix;
			kbd_push <= kbd_valid;
			if (kbd_valid) begin
				// e0 marks extended, f0 marks release, byte 1 clears both first
				key_ext_r <= (bus.data == `USER_IO_KBD_EXT) | (key_ext_r & ~kbd_first);
				key_rel_r <= (bus.data == `USER_IO_KBD_BREAK) | (key_rel_r & ~kbd_first);
			end
		end
	end

endmodule

//--- hw/ps2_kbd_fifo.sv
// keyboard byte queue between the command decoder and the PS/2 transmitter, req/ack on the read side
`timescale 1ns/1ps
`include "user_io_consts.svh"

module ps2_kbd_fifo (
	input  logic                       clk_sys,
	input  logic                       SPI_SS_IO,
	input  logic                       kbd_push,
	input  logic [`USER_IO_BYTE_W-1:0] kbd_push_data,
	output logic                       kbd_req,
	output logic [`USER_IO_BYTE_W-1:0] kbd_byte,
	input  logic                       kbd_ack
);

	localparam int DEPTH = `USER_IO_PS2_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	logic [`USER_IO_BYTE_W-1:0] mem [DEPTH];
	// pointers wrap on their own since DEPTH is a power of two
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0] count;

	logic push_ok;
	logic pop;

	// full queue drops the byte
	assign push_ok = kbd_push && (count != (AW+1)'(DEPTH));
	// ack seen while req is up, the head has been taken
	assign pop = kbd_req && kbd_ack;
	// head stays put until the pop
	assign kbd_byte = mem[rptr];

	always_ff @(posedge clk_sys) begin
		if (push_ok)
			mem[wptr] <= kbd_push_data;
	end

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			kbd_req <= 1'b0;
		end else begin
			if (push_ok)
				wptr <= wptr + 1'b1;
			if (pop)
				rptr <= rptr + 1'b1;
			count <= count + (AW+1)'(push_ok) - (AW+1)'(pop);

			// req goes up only once the previous ack is gone
			if (pop)
				kbd_req <= 1'b0;
			else if (!kbd_req && !kbd_ack && (count != '0))
				kbd_req <= 1'b1;
		end
	end

endmodule

//--- hw/ps2_tx.sv
// PS/2 keyboard serializer; takes bytes from the queue by req/ack and sends eleven-bit frames
`timescale 1ns/1ps
`include "user_io_consts.svh"

module ps2_tx (
	input  logic                       clk_sys,
	input  logic                       SPI_SS_IO,
	input  logic                       kbd_req,
	input  logic [`USER_IO_BYTE_W-1:0] kbd_byte,
	output logic                       kbd_ack,
	output logic                       ps2_kbd_clk,
	output logic                       ps2_kbd_data
);

	localparam int DIV = `USER_IO_PS2_DIV;
	localparam int DW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [DW-1:0] div_cnt;
	// free running PS/2 clock, only shown on the pin during a frame
	logic ps2_clk_r;
	// 0 idle, 1 start, 2..9 data, 10 parity, 11 stop
	logic [3:0] tx_state;
	// byte taken from the queue, waiting for the next PS/2 rising edge
	logic loaded;
	logic [`USER_IO_BYTE_W-1:0] tx_sh;
	logic parity_r;

	logic ps2_rise;

	// this clk_sys edge takes the PS/2 clock from low to high
	assign ps2_rise = (div_cnt == DW'(DIV - 1)) && !ps2_clk_r;
	// clock held high while idle
	assign ps2_kbd_clk = ps2_clk_r | (tx_state == 4'd0);

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			div_cnt <= '0;
			ps2_clk_r <= 1'b1;
			tx_state <= 4'd0;
			loaded <= 1'b0;
			kbd_ack <= 1'b0;
			ps2_kbd_data <= 1'b1;
		end else begin
			// half period of DIV cycles
			if (div_cnt == DW'(DIV - 1)) begin
				div_cnt <= '0;
				ps2_clk_r <= ~ps2_clk_r;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end

			// ack drops after req has dropped
			if (kbd_ack && !kbd_req)
				kbd_ack <= 1'b0;
			else if (!kbd_ack && kbd_req && !loaded && (tx_state == 4'd0))
				kbd_ack <= 1'b1;

			if (ps2_rise) begin
				if (tx_state == 4'd0) begin
					if (loaded) begin
						// start bit
						loaded <= 1'b0;
						ps2_kbd_data <= 1'b0;
						tx_state <= 4'd1;
					end
				end else begin
					if (tx_state <= 4'd8)
						ps2_kbd_data <= tx_sh[0];
					else if (tx_state == 4'd9)
						ps2_kbd_data <= parity_r;
					else
						ps2_kbd_data <= 1'b1;
					// after the stop bit the clock returns to idle
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
				end
			end

			if (!kbd_ack && kbd_req && !loaded && (tx_state == 4'd0))
				loaded <= 1'b1;
		end
	end

	// payload, LSB first
	always_ff @(posedge clk_sys) begin
		if (!kbd_ack && kbd_req && !loaded && (tx_state == 4'd0)) begin
			tx_sh <= kbd_byte;
			// odd parity over data and parity bit
			parity_r <= ~^kbd_byte;
		end else if (ps2_rise && (tx_state >= 4'd1) && (tx_state <= 4'd8)) begin
			tx_sh <= {1'b0, tx_sh[`USER_IO_BYTE_W-1:1]};
		end
	end

endmodule

//--- hw/user_io_top.sv
// top level of the clk_sys user I/O block; connects SPI receiver, decoder, queue and PS/2 sender
`timescale 1ns/1ps
`include "user_io_consts.svh"

module user_io_top (
	input  logic                         clk_sys,
	input  logic                         SPI_SS_IO,
	input  logic                         SPI_CLK,
	input  logic                         SPI_MOSI,
	output logic [`USER_IO_JOY_W-1:0]    joystick_0,
	output logic [`USER_IO_JOY_W-1:0]    joystick_1,
	output logic [1:0]                   buttons,
	output logic [1:0]                   switches,
	output logic [`USER_IO_STATUS_W-1:0] status,
	output logic                         key_pressed,
	output logic                         key_extended,
	output logic [`USER_IO_BYTE_W-1:0]   key_code,
	output logic                         key_strobe,
	output logic                         ps2_kbd_clk,
	output logic                         ps2_kbd_data
);

	import user_io_pkg::*;

	// received bytes, receiver to decoder
	spi_byte_if bus ();

	joy_word_u joy0_u;
	joy_word_u joy1_u;

	// decoder to queue
	logic kbd_push;
	logic [`USER_IO_BYTE_W-1:0] kbd_push_data;
	// queue to PS/2 sender, four-phase
	logic kbd_req;
	logic kbd_ack;
	logic [`USER_IO_BYTE_W-1:0] kbd_byte;

	// flat view on the pins
	assign joystick_0 = joy0_u.word;
	assign joystick_1 = joy1_u.word;

	spi_byte_rx u_rx (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_CLK   (SPI_CLK),
		.SPI_MOSI  (SPI_MOSI),
		.bus       (bus.rx)
	);

	io_cmd_decoder u_dec (
		.clk_sys       (clk_sys),
		.SPI_SS_IO     (SPI_SS_IO),
		.bus           (bus.dec),
		.buttons       (buttons),
		.switches      (switches),
		.joystick_0    (joy0_u),
		.joystick_1    (joy1_u),
		.status        (status),
		.key_pressed   (key_pressed),
		.key_extended  (key_extended),
		.key_code      (key_code),
		.key_strobe    (key_strobe),
		.kbd_push      (kbd_push),
		.kbd_push_data (kbd_push_data)
	);

	ps2_kbd_fifo u_fifo (
		.clk_sys       (clk_sys),
		.SPI_SS_IO     (SPI_SS_IO),
		.kbd_push      (kbd_push),
		.kbd_push_data (kbd_push_data),
		.kbd_req       (kbd_req),
		.kbd_byte      (kbd_byte),
		.kbd_ack       (kbd_ack)
	);

	ps2_tx u_ps2 (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.kbd_req      (kbd_req),
		.kbd_byte     (kbd_byte),
		.kbd_ack      (kbd_ack),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

endmodule

//--- dv/user_io_chk.sv
// concurrent checks on strobes and the queue handshake; bound into the user I/O top level
`timescale 1ns/1ps

module user_io_chk (
	input logic clk_sys,
	input logic SPI_SS_IO,
	input logic key_strobe,
	input logic kbd_req,
	input logic kbd_ack
);

	// one pulse per scan code
	strobe_single: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		key_strobe |=> !key_strobe)
		else $error("key_strobe stayed high for two cycles");

	// ack only answers a pending request
	ack_after_req: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		$rose(kbd_ack) |-> kbd_req)
		else $error("kbd_ack rose without kbd_req");

	// an unanswered request must stay up
	req_held: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		(kbd_req && !kbd_ack) |=> kbd_req)
		else $error("kbd_req dropped before kbd_ack");

	// no strobes outside a frame
	strobe_in_frame: assert property (@(posedge clk_sys)
		SPI_SS_IO |-> !key_strobe)
		else $error("key_strobe high while SPI_SS_IO is high");

endmodule

//--- dv/user_io_tb.sv
// testbench top for the user I/O block; replays SPI frames from the stimulus file and checks outputs
`timescale 1ns/1ps

module user_io_tb;

	// limit for every wait, in clk_sys cycles
	localparam int WAIT_LIMIT = 4000;

	logic clk_sys = 1'b0;
	logic SPI_SS_IO;
	logic SPI_CLK;
	logic SPI_MOSI;

	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic [63:0] status;
	logic key_pressed;
	logic key_extended;
	logic [7:0] key_code;
	logic key_strobe;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;

	// {pressed, extended, code} for each strobe seen
	logic [9:0] key_q [$];
	int strobe_cnt;
	// bytes rebuilt from the PS/2 pins
	logic [7:0] ps2_q [$];
	logic [10:0] ps2_bits;
	int ps2_pos;
	logic ps2_clk_prev = 1'b1;
	// bytes of the next frame, command first
	logic [7:0] frame_q [$];
	int stim_fd;

	// 8 ns period
	always #4 clk_sys = ~clk_sys;

	user_io_top DUT (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.SPI_CLK      (SPI_CLK),
		.SPI_MOSI     (SPI_MOSI),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.buttons      (buttons),
		.switches     (switches),
		.status       (status),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_strobe   (key_strobe),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

	bind user_io_top user_io_chk u_chk (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.key_strobe (key_strobe),
		.kbd_req    (kbd_req),
		.kbd_ack    (kbd_ack)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
			fail_run($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// advance n clocks, landing 1 ns after the rising edge
	task automatic step_clocks(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	// MSB first, MOSI set up while SPI_CLK is low
	task automatic send_byte(input logic [7:0] b, input int per);
		logic [7:0] sh;
		sh = b;
		repeat (8) begin
			SPI_MOSI = sh[7];
			SPI_CLK = 1'b0;
			step_clocks(per - per / 2);
			SPI_CLK = 1'b1;
			step_clocks(per / 2);
			sh = sh << 1;
		end
		SPI_CLK = 1'b0;
	endtask

	// SPI_SS_IO stays low afterwards so queued PS/2 bytes can drain
	task automatic send_frame();
		int per;
		per = 8 + int'($urandom % 32'd5);
		key_q.delete();
		strobe_cnt = 0;
		SPI_SS_IO = 1'b0;
		step_clocks(2);
		while (frame_q.size() > 0)
			send_byte(frame_q.pop_front(), per);
		// last byte still has to cross the synchronizers and the decoder
		step_clocks(per);
	endtask

	task automatic ss_idle();
		SPI_SS_IO = 1'b1;
		step_clocks(3);
	endtask

	task automatic read_hex(output logic [63:0] val);
		int rc;
		val = '0;
		rc = $fscanf(stim_fd, "%h", val);
		if (rc != 1)
			fail_run("stimulus file has a missing or malformed value");
	endtask

	task automatic wait_key(output logic [9:0] ev);
		int n;
		n = 0;
		ev = '0;
		while (key_q.size() == 0 && n < WAIT_LIMIT) begin
			step_clocks(1);
			n++;
		end
		if (key_q.size() == 0)
			fail_run("timeout while waiting for a key strobe");
		else
			ev = key_q.pop_front();
	endtask

	task automatic wait_ps2(output logic [7:0] b);
		int n;
		n = 0;
		b = '0;
		while (ps2_q.size() == 0 && n < WAIT_LIMIT) begin
			step_clocks(1);
			n++;
		end
		if (ps2_q.size() == 0)
			fail_run("timeout while waiting for a PS/2 byte");
		else
			b = ps2_q.pop_front();
	endtask

	// bit 0 start, 8..1 data LSB first, 9 parity, 10 stop
	task automatic check_ps2_frame(input logic [10:0] fr);
		logic [8:0] t;
		int ones;
		t = fr[9:1];
		ones = 0;
		repeat (9) begin
			ones = ones + int'(t[0]);
			t = t >> 1;
		end
		check_value("ps2_kbd_data start bit", 64'(fr[0]), 64'(0));
		check_value("ps2_kbd_data stop bit", 64'(fr[10]), 64'(1));
		// data plus parity must hold an odd number of ones
		check_value("ps2_kbd_data parity", 64'(ones % 2), 64'(1));
		ps2_q.push_back(fr[8:1]);
	endtask

	// strobes sampled mid-cycle
	always @(negedge clk_sys) begin
		if (key_strobe === 1'b1) begin
			key_q.push_back({key_pressed, key_extended, key_code});
			strobe_cnt++;
		end
	end

	// PS/2 receiver, takes data on each falling edge of ps2_kbd_clk
	always @(negedge clk_sys) begin
		if (SPI_SS_IO !== 1'b0) begin
			ps2_pos = 0;
			ps2_clk_prev = 1'b1;
		end else begin
			if (ps2_clk_prev && !ps2_kbd_clk) begin
				ps2_bits = {ps2_kbd_data, ps2_bits[10:1]};
				ps2_pos++;
				if (ps2_pos == 11) begin
					check_ps2_frame(ps2_bits);
					ps2_pos = 0;
				end
			end
			ps2_clk_prev = ps2_kbd_clk;
		end
	end

	initial begin
		int rc;
		int c;
		int n;
		logic [127:0] raw;
		string tok;
		logic [63:0] val;
		logic [63:0] kc;
		logic [63:0] kp;
		logic [63:0] ke;
		logic [9:0] ev;
		logic [7:0] b;

		SPI_SS_IO = 1'b1;
		SPI_CLK = 1'b0;
		SPI_MOSI = 1'b0;
		strobe_cnt = 0;
		rc = $urandom(63);

		// reset for 3 cycles, then the idle levels
		step_clocks(3);
		check_value("key_strobe", 64'(key_strobe), 64'(0));
		check_value("ps2_kbd_clk", 64'(ps2_kbd_clk), 64'(1));
		check_value("ps2_kbd_data", 64'(ps2_kbd_data), 64'(1));

		stim_fd = $fopen("dv/user_io_stimulus.txt", "r");
		if (stim_fd == 0)
			fail_run("cannot open dv/user_io_stimulus.txt");

		raw = '0;
		rc = $fscanf(stim_fd, "%s", raw);
		while (rc == 1) begin
			case (raw)
				128'("#"): begin
					// skip the rest of a comment line
					c = 0;
					while (c != 10 && c != -1)
						c = $fgetc(stim_fd);
				end
				128'("idle"): ss_idle();
				128'("buttons"): begin
					read_hex(val);
					check_value("buttons", 64'(buttons), val);
				end
				128'("switches"): begin
					read_hex(val);
					check_value("switches", 64'(switches), val);
				end
				128'("joy0"): begin
					read_hex(val);
					check_value("joystick_0", 64'(joystick_0), val);
				end
				128'("joy1"): begin
					read_hex(val);
					check_value("joystick_1", 64'(joystick_1), val);
				end
				128'("status"): begin
					read_hex(val);
					check_value("status", status, val);
				end
				128'("strobes"): begin
					read_hex(val);
					check_value("key_strobe count", 64'(strobe_cnt), val);
				end
				128'("key"): begin
					read_hex(kc);
					read_hex(kp);
					read_hex(ke);
					wait_key(ev);
					check_value("key_code", 64'(ev[7:0]), kc);
					check_value("key_pressed", 64'(ev[9]), kp);
					check_value("key_extended", 64'(ev[8]), ke);
				end
				128'("ps2"): begin
					read_hex(val);
					wait_ps2(b);
					check_value("ps2_kbd_data byte", 64'(b), val);
				end
				default: begin
					// a bare decimal count opens a frame
					n = 0;
					// the string form drops the leading zero bytes of the token
					tok = string'(raw);
					rc = $sscanf(tok, "%d", n);
					if (rc != 1 || n < 1 || n > 16) begin
						fail_run("stimulus file has a line that is not understood");
					end else begin
						repeat (n) begin
							read_hex(val);
							frame_q.push_back(val[7:0]);
						end
						send_frame();
					end
				end
			endcase
			raw = '0;
			rc = $fscanf(stim_fd, "%s", raw);
		end
		$fclose(stim_fd);

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- user_io.f
+incdir+hw
hw/user_io_pkg.sv
hw/spi_byte_if.sv
hw/spi_byte_rx.sv
hw/io_cmd_decoder.sv
hw/ps2_kbd_fifo.sv
hw/ps2_tx.sv
hw/user_io_top.sv
dv/user_io_chk.sv
dv/user_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the user I/O testbench with Verilator and runs it; exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module user_io_tb \
	--Mdir obj_dir \
	-o user_io_sim \
	-f user_io.f

# run from the project root so the stimulus path resolves
./obj_dir/user_io_sim

//--- dv/user_io_stimulus.txt
# a bare count starts a frame: count (decimal, command included), then the bytes in hex
# checks: buttons|switches|joy0|joy1|status|strobes|ps2 <hex>; key <code> <pressed> <ext>
2 01 0d
buttons 1
switches 3
idle
buttons 1
switches 3
5 60 11 22 33 44
idle
joy0 44332211
5 61 a5 5a 0f f0
idle
joy1 f00f5aa5
joy0 44332211
9 1e 01 23 45 67 89 ab cd ef
idle
status efcdab8967452301
2 15 3c
idle
status 3c
switches 3
5 05 1c e0 f0 75
key 1c 1 0
key 75 0 1
strobes 2
ps2 1c
ps2 e0
ps2 f0
ps2 75
idle
buttons 1
